// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [7:0]  imem_idx_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [11:0] apb_addr_t;

	localparam int IMEM_DEPTH = 256;
	localparam int NUM_REGS   = 32;

	localparam imem_idx_t START_INDEX = 8'd0;
	localparam word_t     START_PC    = 32'h8002_0000; // Byte address of word 0
	localparam apb_addr_t CTRL_ADDR   = 12'h400;

	// Major opcodes
	localparam opcode_t OP_RTYPE = 6'b000000;
	localparam opcode_t OP_ADDI  = 6'b001000;
	localparam opcode_t OP_ADDIU = 6'b001001;
	localparam opcode_t OP_SLTI  = 6'b001010;
	localparam opcode_t OP_ORI   = 6'b001101;
	localparam opcode_t OP_XORI  = 6'b001110;
	localparam opcode_t OP_LUI   = 6'b001111;

	// R-type function codes
	localparam funct_t FN_SLL  = 6'b000000;
	localparam funct_t FN_SRL  = 6'b000010;
	localparam funct_t FN_SRA  = 6'b000011;
	localparam funct_t FN_ADD  = 6'b100000;
	localparam funct_t FN_ADDU = 6'b100001;
	localparam funct_t FN_SUB  = 6'b100010;
	localparam funct_t FN_SUBU = 6'b100011;
	localparam funct_t FN_AND  = 6'b100100;
	localparam funct_t FN_OR   = 6'b100101;
	localparam funct_t FN_XOR  = 6'b100110;
	localparam funct_t FN_NOR  = 6'b100111;
	localparam funct_t FN_SLT  = 6'b101010;
	localparam funct_t FN_SLTU = 6'b101011;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI,
		ALU_NONE // Dropped or unknown, no write-back
	} alu_op_t;

	typedef enum logic {
		IDLE,
		RUN
	} run_state_t;

endpackage

`default_nettype wire

// ==== issue_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface issue_if;
	logic              valid;
	cpu_pkg::alu_op_t  op;
	cpu_pkg::reg_idx_t rd;
	cpu_pkg::word_t    src_a;
	cpu_pkg::word_t    src_b;
	cpu_pkg::reg_idx_t a_reg; // Source register of a, 0 if none
	cpu_pkg::reg_idx_t b_reg; // Source register of b, 0 if none
	logic [4:0]        shamt;

	modport source (
		output valid, op, rd, src_a, src_b, a_reg, b_reg, shamt
	);

	modport sink (
		input valid, op, rd, src_a, src_b, a_reg, b_reg, shamt
	);
endinterface

`default_nettype wire

// ==== apb_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_loader (
	input  wire                 clock,
	input  wire                 rst,
	input  wire                 psel,
	input  wire                 penable,
	input  wire                 pwrite,
	input  wire cpu_pkg::apb_addr_t paddr,
	input  wire cpu_pkg::word_t pwdata,
	input  wire                 busy,
	input  wire cpu_pkg::word_t imem_rdata,
	output cpu_pkg::word_t      prdata,
	output logic                pready,
	output logic                pslverr,
	output logic                imem_we,
	output cpu_pkg::imem_idx_t  imem_waddr,
	output cpu_pkg::word_t      imem_wdata,
	output logic                start,
	output cpu_pkg::imem_idx_t  run_count
);

	logic setup_phase;
	logic access_phase;
	logic in_mem;
	logic is_ctrl;
	logic err_q;

	assign setup_phase  = psel & ~penable;
	assign access_phase = psel & penable;
	assign in_mem       = paddr < cpu_pkg::CTRL_ADDR;
	assign is_ctrl      = paddr == cpu_pkg::CTRL_ADDR;

	// Error decided in the setup cycle, reported and applied in the access cycle
	always_ff @(posedge clock) begin
		if (rst) begin
			err_q <= 1'b0;
		end else if (setup_phase) begin
			err_q <= ~(in_mem | is_ctrl) | (pwrite & busy);
		end
	end

	assign pready  = 1'b1;
	assign pslverr = access_phase & err_q;

	assign imem_we    = access_phase & pwrite & in_mem & ~err_q;
	assign imem_waddr = paddr[9:2]; // Also the readback address
	assign imem_wdata = pwdata;

	assign start     = access_phase & pwrite & is_ctrl & ~err_q;
	assign run_count = pwdata[7:0];

	always_comb begin
		if (is_ctrl) begin
			prdata = {31'b0, busy};
		end else if (in_mem) begin
			prdata = imem_rdata;
		end else begin
			prdata = '0;
		end
	end

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  wire                     clock,
	input  wire                     rst,
	input  wire                     imem_we,
	input  wire cpu_pkg::imem_idx_t imem_waddr,
	input  wire cpu_pkg::word_t     imem_wdata,
	input  wire                     start,
	input  wire cpu_pkg::imem_idx_t run_count,
	output cpu_pkg::word_t          imem_rdata,
	output cpu_pkg::word_t          insn,
	output logic                    insn_valid,
	output logic                    fetch_done
);

	cpu_pkg::word_t      mem [cpu_pkg::IMEM_DEPTH];
	cpu_pkg::run_state_t state;
	cpu_pkg::imem_idx_t  idx;
	cpu_pkg::imem_idx_t  last_idx;

	// One write port, one fetch read, one readback read
	always_ff @(posedge clock) begin
		if (imem_we) begin
			mem[imem_waddr] <= imem_wdata;
		end
		imem_rdata <= mem[imem_waddr];
		if (state == cpu_pkg::RUN) begin
			insn <= mem[idx];
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state      <= cpu_pkg::IDLE;
			idx        <= cpu_pkg::START_INDEX;
			last_idx   <= cpu_pkg::START_INDEX;
			insn_valid <= 1'b0;
		end else begin
			insn_valid <= (state == cpu_pkg::RUN); // Word returns a cycle after its index
			case (state)
				cpu_pkg::IDLE: begin
					if (start && run_count != 8'd0) begin
						state    <= cpu_pkg::RUN;
						idx      <= cpu_pkg::START_INDEX;
						last_idx <= cpu_pkg::START_INDEX + run_count - 8'd1;
					end
				end
				cpu_pkg::RUN: begin
					idx <= idx + 8'd1;
					if (idx == last_idx) begin
						state <= cpu_pkg::IDLE;
					end
				end
				default: begin
					state <= cpu_pkg::IDLE;
				end
			endcase
		end
	end

	// Every index of the run has been issued
	assign fetch_done = (state == cpu_pkg::IDLE);

endmodule

`default_nettype wire

// ==== register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  wire                    clock,
	input  wire                    rst,
	input  wire cpu_pkg::reg_idx_t ra_a,
	input  wire cpu_pkg::reg_idx_t ra_b,
	input  wire                    we,
	input  wire cpu_pkg::reg_idx_t wa,
	input  wire cpu_pkg::word_t    wd,
	output cpu_pkg::word_t         rd_a,
	output cpu_pkg::word_t         rd_b
);

	cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	// Write-through so decode sees the value retiring this cycle
	function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_idx_t ra);
		if (ra == 5'd0) begin
			return '0;
		end
		if (we && wa == ra) begin
			return wd;
		end
		return regs[ra];
	endfunction

	always_comb begin
		rd_a = read_port(ra_a);
		rd_b = read_port(ra_b);
	end

endmodule

`default_nettype wire

// ==== decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
	input  wire                 clock,
	input  wire                 rst,
	input  wire cpu_pkg::word_t insn,
	input  wire                 insn_valid,
	input  wire cpu_pkg::word_t rf_rd_a,
	input  wire cpu_pkg::word_t rf_rd_b,
	output cpu_pkg::reg_idx_t   rf_ra_a,
	output cpu_pkg::reg_idx_t   rf_ra_b,
	issue_if.source             issue
);

	cpu_pkg::opcode_t  opcode;
	cpu_pkg::reg_idx_t rs;
	cpu_pkg::reg_idx_t rt;
	cpu_pkg::reg_idx_t rd;
	logic [4:0]        shamt;
	cpu_pkg::funct_t   funct;
	logic [15:0]       imm;
	cpu_pkg::word_t    imm_sx;
	cpu_pkg::word_t    imm_zx;

	cpu_pkg::alu_op_t  op_d;
	cpu_pkg::reg_idx_t dest_d;
	cpu_pkg::word_t    b_d;
	cpu_pkg::reg_idx_t a_reg_d;
	cpu_pkg::reg_idx_t b_reg_d;

	assign opcode = insn[31:26];
	assign rs     = insn[25:21];
	assign rt     = insn[20:16];
	assign rd     = insn[15:11];
	assign shamt  = insn[10:6];
	assign funct  = insn[5:0];
	assign imm    = insn[15:0];
	assign imm_sx = {{16{imm[15]}}, imm};
	assign imm_zx = {16'h0000, imm};

	assign rf_ra_a = rs;
	assign rf_ra_b = rt;

	always_comb begin
		op_d    = cpu_pkg::ALU_NONE;
		dest_d  = rt; // I-type writes rt
		b_d     = imm_sx;
		a_reg_d = rs;
		b_reg_d = 5'd0;
		case (opcode)
			cpu_pkg::OP_RTYPE: begin
				dest_d  = rd;
				b_d     = rf_rd_b;
				b_reg_d = rt;
				case (funct)
					cpu_pkg::FN_ADD, cpu_pkg::FN_ADDU: op_d = cpu_pkg::ALU_ADD;
					cpu_pkg::FN_SUB, cpu_pkg::FN_SUBU: op_d = cpu_pkg::ALU_SUB;
					cpu_pkg::FN_AND:  op_d = cpu_pkg::ALU_AND;
					cpu_pkg::FN_OR:   op_d = cpu_pkg::ALU_OR;
					cpu_pkg::FN_XOR:  op_d = cpu_pkg::ALU_XOR;
					cpu_pkg::FN_NOR:  op_d = cpu_pkg::ALU_NOR;
					cpu_pkg::FN_SLT:  op_d = cpu_pkg::ALU_SLT;
					cpu_pkg::FN_SLTU: op_d = cpu_pkg::ALU_SLTU;
					cpu_pkg::FN_SLL, cpu_pkg::FN_SRL, cpu_pkg::FN_SRA: begin
						a_reg_d = 5'd0; // Shifts only read rt
						case (funct)
							cpu_pkg::FN_SLL: op_d = cpu_pkg::ALU_SLL;
							cpu_pkg::FN_SRL: op_d = cpu_pkg::ALU_SRL;
							default:         op_d = cpu_pkg::ALU_SRA;
						endcase
					end
					default: op_d = cpu_pkg::ALU_NONE;
				endcase
			end
			cpu_pkg::OP_ADDI, cpu_pkg::OP_ADDIU: op_d = cpu_pkg::ALU_ADD;
			cpu_pkg::OP_SLTI: op_d = cpu_pkg::ALU_SLT;
			cpu_pkg::OP_ORI: begin
				op_d = cpu_pkg::ALU_OR;
				b_d  = imm_zx;
			end
			cpu_pkg::OP_XORI: begin
				op_d = cpu_pkg::ALU_XOR;
				b_d  = imm_zx;
			end
			cpu_pkg::OP_LUI: begin
				op_d    = cpu_pkg::ALU_LUI;
				b_d     = imm_zx;
				a_reg_d = 5'd0;
			end
			default: op_d = cpu_pkg::ALU_NONE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			issue.valid <= 1'b0;
		end else begin
			issue.valid <= insn_valid;
		end
	end

	always_ff @(posedge clock) begin
		issue.op    <= op_d;
		issue.rd    <= dest_d;
		issue.src_a <= rf_rd_a;
		issue.src_b <= b_d;
		issue.a_reg <= a_reg_d;
		issue.b_reg <= b_reg_d;
		issue.shamt <= shamt;
	end

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire             clock,
	input  wire             rst,
	issue_if.sink           issue,
	output logic            wb_valid,
	output cpu_pkg::reg_idx_t wb_reg,
	output cpu_pkg::word_t  wb_data
);

	cpu_pkg::word_t a;
	cpu_pkg::word_t b;
	cpu_pkg::word_t result;

	// Previous result still sits in write-back, not yet in the register file.
	// Register 0 never matches since it never raises wb_valid
	assign a = (wb_valid && wb_reg == issue.a_reg) ? wb_data : issue.src_a;
	assign b = (wb_valid && wb_reg == issue.b_reg) ? wb_data : issue.src_b;

	always_comb begin
		case (issue.op)
			cpu_pkg::ALU_ADD:  result = a + b; // Wraps, no overflow trap
			cpu_pkg::ALU_SUB:  result = a - b;
			cpu_pkg::ALU_AND:  result = a & b;
			cpu_pkg::ALU_OR:   result = a | b;
			cpu_pkg::ALU_XOR:  result = a ^ b;
			cpu_pkg::ALU_NOR:  result = ~(a | b);
			cpu_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
			cpu_pkg::ALU_SLTU: result = {31'b0, a < b};
			cpu_pkg::ALU_SLL:  result = b << issue.shamt;
			cpu_pkg::ALU_SRL:  result = b >> issue.shamt;
			cpu_pkg::ALU_SRA:  result = cpu_pkg::word_t'($signed(b) >>> issue.shamt);
			cpu_pkg::ALU_LUI:  result = {b[15:0], 16'h0000};
			default:           result = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= issue.valid && issue.op != cpu_pkg::ALU_NONE && issue.rd != 5'd0;
		end
	end

	always_ff @(posedge clock) begin
		wb_reg  <= issue.rd;
		wb_data <= result;
	end

endmodule

`default_nettype wire

// ==== mips_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core_top (
	input  wire                     clock,
	input  wire                     rst,
	input  wire                     psel,
	input  wire                     penable,
	input  wire                     pwrite,
	input  wire cpu_pkg::apb_addr_t paddr,
	input  wire cpu_pkg::word_t     pwdata,
	output cpu_pkg::word_t          prdata,
	output logic                    pready,
	output logic                    pslverr,
	output logic                    busy,
	output logic                    wb_valid,
	output cpu_pkg::reg_idx_t       wb_reg,
	output cpu_pkg::word_t          wb_data
);

	logic               imem_we;
	cpu_pkg::imem_idx_t imem_waddr;
	cpu_pkg::word_t     imem_wdata;
	cpu_pkg::word_t     imem_rdata;
	logic               start;
	cpu_pkg::imem_idx_t run_count;
	cpu_pkg::word_t     insn;
	logic               insn_valid;
	logic               fetch_done;
	cpu_pkg::reg_idx_t  rf_ra_a;
	cpu_pkg::reg_idx_t  rf_ra_b;
	cpu_pkg::word_t     rf_rd_a;
	cpu_pkg::word_t     rf_rd_b;

	issue_if issue_bus ();

	// Held until the last instruction has left write-back
	assign busy = ~fetch_done | insn_valid | issue_bus.valid | wb_valid;

	apb_loader u_apb_loader (
		.clock, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .busy, .imem_rdata,
		.prdata, .pready, .pslverr, .imem_we, .imem_waddr, .imem_wdata, .start, .run_count
	);

	fetch_unit u_fetch_unit (
		.clock, .rst, .imem_we, .imem_waddr, .imem_wdata, .start, .run_count,
		.imem_rdata, .insn, .insn_valid, .fetch_done
	);

	decode_unit u_decode_unit (
		.clock, .rst, .insn, .insn_valid, .rf_rd_a, .rf_rd_b, .rf_ra_a, .rf_ra_b,
		.issue (issue_bus.source)
	);

	register_file u_register_file (
		.clock, .rst, .ra_a (rf_ra_a), .ra_b (rf_ra_b),
		.we (wb_valid), .wa (wb_reg), .wd (wb_data), .rd_a (rf_rd_a), .rd_b (rf_rd_b)
	);

	alu u_alu (
		.clock, .rst, .issue (issue_bus.sink), .wb_valid, .wb_reg, .wb_data
	);

endmodule

`default_nettype wire

// ==== tb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core;

	localparam int N_RANDOM    = 64;
	localparam int N_DENSE     = 96;
	localparam int CYCLE_LIMIT = 20 * (N_RANDOM + N_DENSE) + 2000;

	localparam cpu_pkg::funct_t R_FUNCTS [13] = '{cpu_pkg::FN_ADDU, cpu_pkg::FN_SUBU,
		cpu_pkg::FN_AND, cpu_pkg::FN_OR, cpu_pkg::FN_XOR, cpu_pkg::FN_NOR, cpu_pkg::FN_SLT,
		cpu_pkg::FN_SLTU, cpu_pkg::FN_SLL, cpu_pkg::FN_SRL, cpu_pkg::FN_SRA, cpu_pkg::FN_ADD,
		cpu_pkg::FN_SUB};
	localparam cpu_pkg::opcode_t I_OPS [6] = '{cpu_pkg::OP_ADDIU, cpu_pkg::OP_ADDI,
		cpu_pkg::OP_ORI, cpu_pkg::OP_XORI, cpu_pkg::OP_SLTI, cpu_pkg::OP_LUI};
	// LW, BEQ, J and an unused opcode
	localparam cpu_pkg::opcode_t DROPPED_OPS [4] = '{6'b100011, 6'b000100, 6'b000010, 6'b111111};
	localparam cpu_pkg::funct_t FN_MULT = 6'b011000;

	logic clock;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	cpu_pkg::apb_addr_t paddr;
	cpu_pkg::word_t pwdata;
	cpu_pkg::word_t prdata;
	logic pready;
	logic pslverr;
	logic busy;
	logic wb_valid;
	cpu_pkg::reg_idx_t wb_reg;
	cpu_pkg::word_t wb_data;

	int value_errors = 0;
	int protocol_errors = 0;
	int cycles = 0;
	int wb_checked = 0;
	logic [31:0] rng_state = 32'd51178;
	cpu_pkg::word_t model_regs [32];
	cpu_pkg::word_t prog [cpu_pkg::IMEM_DEPTH];
	logic [36:0] exp_q [$]; // {reg, data}
	logic [36:0] got_q [$];

	mips_core_top UUT (
		.clock, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
		.busy, .wb_valid, .wb_reg, .wb_data
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run was still going after %0d cycles", cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	always @(posedge clock) begin
		if (!rst && wb_valid) begin
			got_q.push_back({wb_reg, wb_data});
		end
	end

	assert property (@(posedge clock) disable iff (rst) wb_valid |-> wb_reg != 5'd0)
		else begin
			protocol_errors++;
			$display("FAILED %0t: write-back pulse for register 0", $time);
		end

	assert property (@(posedge clock) disable iff (rst) pready && (!pslverr || (psel && penable)))
		else begin
			protocol_errors++;
			$display("FAILED %0t: APB response outside an access cycle", $time);
		end

	function automatic logic [31:0] xorshift();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Small mask packs operands into few registers, so results chain
	function automatic cpu_pkg::word_t gen_insn(input logic [4:0] mask);
		logic [31:0] r;
		logic [31:0] f;
		int sel;
		r   = xorshift();
		f   = xorshift();
		sel = int'(r % 32'd24);
		if (sel < 13) begin
			return {cpu_pkg::OP_RTYPE, f[4:0] & mask, f[9:5] & mask, f[14:10] & mask, f[19:15],
				R_FUNCTS[sel]};
		end
		if (sel < 19) begin
			return {I_OPS[sel - 13], f[4:0] & mask, f[9:5] & mask, f[31:16]};
		end
		if (sel < 23) begin
			return {DROPPED_OPS[sel - 19], f[25:0]};
		end
		return {cpu_pkg::OP_RTYPE, f[19:0], FN_MULT};
	endfunction

	task automatic model_step(input cpu_pkg::word_t w);
		cpu_pkg::reg_idx_t dest;
		cpu_pkg::word_t a, b, sx, zx, res;
		logic writes;
		a      = model_regs[w[25:21]];
		b      = model_regs[w[20:16]];
		sx     = {{16{w[15]}}, w[15:0]};
		zx     = {16'h0000, w[15:0]};
		dest   = w[20:16];
		writes = 1'b1;
		res    = '0;
		if (w[31:26] == cpu_pkg::OP_RTYPE) begin
			dest = w[15:11];
			case (w[5:0])
				cpu_pkg::FN_ADD, cpu_pkg::FN_ADDU: res = a + b;
				cpu_pkg::FN_SUB, cpu_pkg::FN_SUBU: res = a - b;
				cpu_pkg::FN_AND:  res = a & b;
				cpu_pkg::FN_OR:   res = a | b;
				cpu_pkg::FN_XOR:  res = a ^ b;
				cpu_pkg::FN_NOR:  res = ~(a | b);
				cpu_pkg::FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
				cpu_pkg::FN_SLTU: res = {31'b0, a < b};
				cpu_pkg::FN_SLL:  res = b << w[10:6];
				cpu_pkg::FN_SRL:  res = b >> w[10:6];
				cpu_pkg::FN_SRA:  res = cpu_pkg::word_t'($signed(b) >>> w[10:6]);
				default:          writes = 1'b0;
			endcase
		end else begin
			case (w[31:26])
				cpu_pkg::OP_ADDI, cpu_pkg::OP_ADDIU: res = a + sx;
				cpu_pkg::OP_SLTI: res = {31'b0, $signed(a) < $signed(sx)};
				cpu_pkg::OP_ORI:  res = a | zx;
				cpu_pkg::OP_XORI: res = a ^ zx;
				cpu_pkg::OP_LUI:  res = {w[15:0], 16'h0000};
				default:          writes = 1'b0;
			endcase
		end
		if (writes && dest != 5'd0) begin
			model_regs[dest] = res;
			exp_q.push_back({dest, res});
		end
	endtask

	// Setup cycle, access cycle, then one idle cycle
	task automatic apb_transfer(input logic write, input cpu_pkg::apb_addr_t addr,
			input cpu_pkg::word_t wdata, input logic expect_err, output cpu_pkg::word_t rdata);
		@(posedge clock);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clock);
		#1;
		penable = 1'b1;
		#1;
		rdata = prdata;
		assert (pslverr == expect_err)
			else begin
				value_errors++;
				$display("FAILED %0t: pslverr %0b at address %h, expected %0b", $time, pslverr,
					addr, expect_err);
			end
		@(posedge clock);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic check_readback(input int n);
		cpu_pkg::word_t rdata;
		for (int i = 0; i < n; i++) begin
			apb_transfer(1'b0, cpu_pkg::apb_addr_t'(i * 4), '0, 1'b0, rdata);
			assert (rdata == prog[i])
				else begin
					value_errors++;
					$display("FAILED %0t: word %0d reads %h, expected %h", $time, i, rdata, prog[i]);
				end
		end
	endtask

	task automatic wait_idle();
		cpu_pkg::word_t status;
		status = 32'd1;
		while (status[0]) begin
			apb_transfer(1'b0, cpu_pkg::CTRL_ADDR, '0, 1'b0, status);
		end
		assert (status == 32'd0)
			else begin
				value_errors++;
				$display("FAILED %0t: control register reads %h when idle", $time, status);
			end
	endtask

	task automatic run_program(input int n, input logic [4:0] mask, input logic bad_access);
		cpu_pkg::word_t rdata;
		exp_q.delete();
		got_q.delete();
		for (int i = 0; i < n; i++) begin
			prog[i] = gen_insn(mask);
			model_step(prog[i]);
			apb_transfer(1'b1, cpu_pkg::apb_addr_t'(i * 4), prog[i], 1'b0, rdata);
		end
		apb_transfer(1'b1, cpu_pkg::CTRL_ADDR, cpu_pkg::word_t'(n), 1'b0, rdata);
		apb_transfer(1'b0, cpu_pkg::CTRL_ADDR, '0, 1'b0, rdata);
		assert (rdata == 32'd1)
			else begin
				value_errors++;
				$display("FAILED %0t: busy reads %h during a run", $time, rdata);
			end
		if (bad_access) begin
			apb_transfer(1'b1, 12'h000, ~prog[0], 1'b1, rdata); // Blocked while busy
			apb_transfer(1'b1, cpu_pkg::CTRL_ADDR, 32'd5, 1'b1, rdata);
			apb_transfer(1'b0, 12'hFFC, '0, 1'b1, rdata);
		end
		wait_idle();
		assert (got_q.size() == exp_q.size())
			else begin
				value_errors++;
				$display("FAILED %0t: %0d write-backs, expected %0d", $time, got_q.size(),
					exp_q.size());
			end
		for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
			wb_checked++;
			assert (got_q[i] == exp_q[i])
				else begin
					value_errors++;
					$display("FAILED %0t: write-back %0d is r%0d=%h, expected r%0d=%h", $time, i,
						got_q[i][36:32], got_q[i][31:0], exp_q[i][36:32], exp_q[i][31:0]);
				end
		end
		if (bad_access) begin
			apb_transfer(1'b1, 12'h800, ~prog[0], 1'b1, rdata); // Unmapped, core idle
			check_readback(n);
		end
	endtask

	initial begin
		cpu_pkg::word_t rdata;
		rst     = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		repeat (3) @(posedge clock);
		#1;
		rst = 1'b0;
		assert (!busy && !wb_valid && !pslverr)
			else begin
				value_errors++;
				$display("FAILED %0t: busy, wb_valid or pslverr high after reset", $time);
			end
		for (int i = 0; i < 32; i++) begin
			prog[i] = cpu_pkg::word_t'(i) * 32'h9E37_79B1 + 32'h0F0F_0000;
			apb_transfer(1'b1, cpu_pkg::apb_addr_t'(i * 4), prog[i], 1'b0, rdata);
		end
		check_readback(32);
		run_program(N_RANDOM, 5'd31, 1'b0);
		run_program(N_DENSE, 5'd3, 1'b1);
		got_q.delete();
		apb_transfer(1'b1, cpu_pkg::CTRL_ADDR, '0, 1'b0, rdata); // Empty run
		apb_transfer(1'b0, cpu_pkg::CTRL_ADDR, '0, 1'b0, rdata);
		repeat (10) @(posedge clock);
		assert (rdata == 32'd0 && got_q.size() == 0)
			else begin
				value_errors++;
				$display("FAILED %0t: empty run gave busy %h and %0d write-backs", $time, rdata,
					got_q.size());
			end
		$display("Summary: %0d value errors, %0d protocol errors, %0d write-backs compared",
			value_errors, protocol_errors, wb_checked);
		if (value_errors + protocol_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
cpu_pkg.sv
issue_if.sv
apb_loader.sv
fetch_unit.sv
register_file.sv
decode_unit.sv
alu.sv
mips_core_top.sv
tb_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_core
FILELIST  = verilog.f
PASS_MSG  = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
